// ==== include/core_settings.svh ====
// core widths and reset vector, included by the package and any RTL file that sizes from them
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// integer register and address width
`define XLEN 64

// fixed 32-bit instruction encoding
`define INST_W 32

// architectural integer registers x0 to x31
`define REG_NUM 32

// first fetch address once reset is released
`define RESET_PC 64'h0000_0000_0000_0000

`endif

// ==== design/rv_pkg.sv ====
// shared types and instruction encodings for the core, imported by each RTL module that uses them
`include "core_settings.svh"

package rv_pkg;

  // data and address word
  typedef logic [`XLEN-1:0] reg_t;

  // raw instruction word
  typedef logic [`INST_W-1:0] inst_t;

  // register index
  typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;

  // major opcode taken from inst[6:2]
  typedef enum logic [4:0] {
    op_imm    = 5'b00100,
    op_auipc  = 5'b00101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011
  } opcode_t;

  typedef logic [2:0] funct3_t;

  // op-imm group
  localparam funct3_t f3_addi  = 3'b000;
  localparam funct3_t f3_slti  = 3'b010;
  localparam funct3_t f3_sltiu = 3'b011;

  // branch group
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

// ==== design/if_stage.sv ====
// fetch stage holding the program counter, steered each clock by the execute stage jump request
`timescale 1ns/10ps
`include "core_settings.svh"

module if_stage (
  input  logic         clk,
  input  logic         rst,
  input  logic         pc_jmp,
  input  rv_pkg::reg_t pc_jmpaddr,
  output rv_pkg::reg_t pc,
  output logic         inst_ena
);

  import rv_pkg::*;

  reg_t pc_next;

  // taken jump or branch wins over the sequential address
  assign pc_next = pc_jmp ? pc_jmpaddr : pc + reg_t'(4);

  // one instruction retires per clock so pc moves every cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // fetch enabled in every cycle out of reset
  assign inst_ena = ~rst;

  // catches misaligned jal or branch targets coming back from decode and execute
  pc_align_a: assert property (@(posedge clk) disable iff (rst)
    inst_ena |-> (pc[1:0] == 2'b00))
    else $error("fetch address %h is not word aligned", pc);

endmodule

// ==== design/id_stage.sv ====
// decode stage that splits the instruction into fields and builds the execute operands
`timescale 1ns/10ps
`include "core_settings.svh"

module id_stage (
  input  rv_pkg::inst_t     inst,
  input  rv_pkg::reg_t      pc,
  input  rv_pkg::reg_t      rs1_data,
  input  rv_pkg::reg_t      rs2_data,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::reg_addr_t rd_addr,
  output rv_pkg::opcode_t   inst_opcode,
  output rv_pkg::funct3_t   inst_funct3,
  output rv_pkg::reg_t      op1,
  output rv_pkg::reg_t      op2,
  output rv_pkg::reg_t      t1
);

  import rv_pkg::*;

  reg_t imm_i;
  reg_t imm_u;
  reg_t imm_j;
  reg_t imm_b;
  reg_t pc_plus4;

  // register fields sit at fixed positions in every format
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  assign inst_opcode = opcode_t'(inst[6:2]);
  assign inst_funct3 = inst[14:12];

  // immediates all sign extend from inst[31]
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};

  // link address for jal and jalr
  assign pc_plus4 = pc + reg_t'(4);

  always_comb begin
    op1 = '0;
    op2 = '0;
    t1  = '0;
    case (inst_opcode)
      op_auipc: begin
        op1 = pc;
        op2 = imm_u;
      end
      op_imm: begin
        op1 = rs1_data;
        op2 = imm_i;
      end
      op_jal: begin
        // op2 already holds the final target
        op1 = pc_plus4;
        op2 = pc + imm_j;
      end
      op_jalr: begin
        op1 = rs1_data;
        op2 = imm_i;
        t1  = pc_plus4;
      end
      op_branch: begin
        // compare rs1 with rs2, t1 is the taken target
        op1 = rs1_data;
        op2 = rs2_data;
        t1  = pc + imm_b;
      end
      default: begin
        // unsupported opcode leaves operands at zero
      end
    endcase
  end

endmodule

// ==== design/exe_stage.sv ====
// execute stage producing the register write, the branch decision and the jump target
`timescale 1ns/10ps

module exe_stage (
  input  logic            rst,
  input  rv_pkg::opcode_t inst_opcode,
  input  rv_pkg::funct3_t inst_funct3,
  input  rv_pkg::reg_t    op1,
  input  rv_pkg::reg_t    op2,
  input  rv_pkg::reg_t    t1,
  output logic            pc_jmp,
  output rv_pkg::reg_t    pc_jmpaddr,
  output logic            rd_wen,
  output rv_pkg::reg_t    rd_wdata
);

  import rv_pkg::*;

  logic br_taken;
  reg_t jalr_sum;

  assign jalr_sum = op1 + op2;

  // condition for the six branch compares
  always_comb begin
    case (inst_funct3)
      f3_beq:  br_taken = (op1 == op2);
      f3_bne:  br_taken = (op1 != op2);
      f3_blt:  br_taken = ($signed(op1) < $signed(op2));
      f3_bge:  br_taken = ($signed(op1) >= $signed(op2));
      f3_bltu: br_taken = (op1 < op2);
      f3_bgeu: br_taken = (op1 >= op2);
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    rd_wen     = 1'b0;
    rd_wdata   = '0;
    pc_jmp     = 1'b0;
    pc_jmpaddr = '0;
    case (inst_opcode)
      op_auipc: begin
        rd_wen   = 1'b1;
        rd_wdata = op1 + op2;
      end
      op_imm: begin
        case (inst_funct3)
          f3_addi: begin
            rd_wen   = 1'b1;
            rd_wdata = op1 + op2;
          end
          f3_slti: begin
            rd_wen   = 1'b1;
            rd_wdata = reg_t'($signed(op1) < $signed(op2));
          end
          f3_sltiu: begin
            rd_wen   = 1'b1;
            rd_wdata = reg_t'(op1 < op2);
          end
          default: begin
            // other op-imm encodings are not implemented
          end
        endcase
      end
      op_jal: begin
        rd_wen     = 1'b1;
        rd_wdata   = op1;
        pc_jmp     = 1'b1;
        pc_jmpaddr = op2;
      end
      op_jalr: begin
        // target drops bit 0 of the sum
        rd_wen     = 1'b1;
        rd_wdata   = t1;
        pc_jmp     = 1'b1;
        pc_jmpaddr = jalr_sum & ~reg_t'(1);
      end
      op_branch: begin
        pc_jmp     = br_taken;
        pc_jmpaddr = t1;
      end
      default: begin
        // no write and fall through to pc + 4
      end
    endcase
    // nothing retires while in reset
    if (rst) begin
      rd_wen = 1'b0;
      pc_jmp = 1'b0;
    end
  end

endmodule

// ==== design/regfile.sv ====
// integer register file with two combinational read ports and one clocked write port
`timescale 1ns/10ps
`include "core_settings.svh"

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::reg_t      rs1_data,
  output rv_pkg::reg_t      rs2_data,
  input  logic              wen,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::reg_t      wdata
);

  import rv_pkg::*;

  reg_t regs [`REG_NUM];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // holds across every write the execute stage has issued since reset
  x0_zero_a: assert property (@(posedge clk) disable iff (rst)
    ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)))
    else $error("x0 read back a nonzero value");

endmodule

// ==== design/rv_core.sv ====
// single-cycle core top joining fetch, decode, execute and the register file
`timescale 1ns/10ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::reg_t      inst_addr,
  output logic              inst_ena,
  input  rv_pkg::inst_t     inst,
  output logic              wb_en,
  output rv_pkg::reg_addr_t wb_addr,
  output rv_pkg::reg_t      wb_data
);

  import rv_pkg::*;

  reg_t      pc;
  logic      pc_jmp;
  reg_t      pc_jmpaddr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_t      rs1_data;
  reg_t      rs2_data;
  opcode_t   inst_opcode;
  funct3_t   inst_funct3;
  reg_t      op1;
  reg_t      op2;
  reg_t      t1;

  assign inst_addr = pc;

  if_stage u_if_stage (
    .clk        (clk),
    .rst        (rst),
    .pc_jmp     (pc_jmp),
    .pc_jmpaddr (pc_jmpaddr),
    .pc         (pc),
    .inst_ena   (inst_ena)
  );

  // rd goes straight to the write port
  id_stage u_id_stage (
    .inst        (inst),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (wb_addr),
    .inst_opcode (inst_opcode),
    .inst_funct3 (inst_funct3),
    .op1         (op1),
    .op2         (op2),
    .t1          (t1)
  );

  exe_stage u_exe_stage (
    .rst         (rst),
    .inst_opcode (inst_opcode),
    .inst_funct3 (inst_funct3),
    .op1         (op1),
    .op2         (op2),
    .t1          (t1),
    .pc_jmp      (pc_jmp),
    .pc_jmpaddr  (pc_jmpaddr),
    .rd_wen      (wb_en),
    .rd_wdata    (wb_data)
  );

  // write port is shared with the observation outputs
  regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (wb_en),
    .waddr    (wb_addr),
    .wdata    (wb_data)
  );

endmodule

// ==== verif/rv_core_tb.sv ====
// testbench for rv_core, runs a hand-encoded program and checks each retirement against a table
`timescale 1ns/10ps
`include "core_settings.svh"

module rv_core_tb;

  import rv_pkg::*;

  localparam int n_entries  = 25;
  localparam int mem_words  = 64;
  localparam int reset_wait = 10;

  // major opcodes from the base ISA
  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr  = 7'b1100111;
  localparam logic [6:0] opc_reg   = 7'b0110011;

  logic      clk;
  logic      rst;
  reg_t      inst_addr;
  logic      inst_ena;
  inst_t     inst;
  logic      wb_en;
  reg_addr_t wb_addr;
  reg_t      wb_data;

  inst_t imem [mem_words];

  // one row per expected retirement
  string     exp_name  [n_entries];
  reg_t      exp_addr  [n_entries];
  logic      exp_wen   [n_entries];
  reg_addr_t exp_waddr [n_entries];
  reg_t      exp_wdata [n_entries];
  int        n_loaded;

  int value_errors;
  int timeout_errors;
  int checks_run;
  int wait_cycles;

  rv_core DUT (
    .clk       (clk),
    .rst       (rst),
    .inst_addr (inst_addr),
    .inst_ena  (inst_ena),
    .inst      (inst),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  // word index is the byte address divided by 4
  assign inst = imem[inst_addr[7:2]];

  always #20 clk = ~clk;

  function automatic inst_t itype_word(input logic [11:0] imm, input reg_addr_t rs1,
                                       input funct3_t f3, input reg_addr_t rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t utype_word(input logic [19:0] imm, input reg_addr_t rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // offset bit 0 is implied zero
  function automatic inst_t jal_word(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic inst_t branch_word(input logic [12:0] off, input reg_addr_t rs1,
                                        input reg_addr_t rs2, input funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  // stores one instruction and the retirement it should produce
  task automatic put_inst(input reg_t addr, input inst_t word, input string name,
                          input logic wen, input reg_addr_t waddr, input reg_t wdata);
    imem[addr[7:2]]     = word;
    exp_name[n_loaded]  = name;
    exp_addr[n_loaded]  = addr;
    exp_wen[n_loaded]   = wen;
    exp_waddr[n_loaded] = waddr;
    exp_wdata[n_loaded] = wdata;
    n_loaded++;
  endtask

  task automatic load_program();
    for (int i = 0; i < mem_words; i++) begin
      // addi x31, x0, byte address marks any stray fetch
      imem[i] = itype_word(12'(i * 4), 5'd0, f3_addi, 5'd31, opc_imm);
    end
    put_inst(64'h00, itype_word(12'd5, 5'd0, f3_addi, 5'd1, opc_imm),
             "reset_first_addi", 1'b1, 5'd1, 64'd5);
    put_inst(64'h04, itype_word(12'hFFD, 5'd0, f3_addi, 5'd2, opc_imm),
             "addi_negative", 1'b1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFD);
    put_inst(64'h08, itype_word(12'd10, 5'd1, f3_addi, 5'd3, opc_imm),
             "addi_chain", 1'b1, 5'd3, 64'd15);
    put_inst(64'h0C, itype_word(12'd7, 5'd1, f3_addi, 5'd0, opc_imm),
             "addi_to_x0", 1'b1, 5'd0, 64'd12);
    put_inst(64'h10, itype_word(12'd9, 5'd0, f3_addi, 5'd4, opc_imm),
             "x0_reads_zero", 1'b1, 5'd4, 64'd9);
    put_inst(64'h14, itype_word(12'd1, 5'd2, f3_slti, 5'd5, opc_imm),
             "slti_negative", 1'b1, 5'd5, 64'd1);
    put_inst(64'h18, itype_word(12'd1, 5'd2, f3_sltiu, 5'd6, opc_imm),
             "sltiu_negative", 1'b1, 5'd6, 64'd0);
    put_inst(64'h1C, utype_word(20'h12345, 5'd7, opc_auipc),
             "auipc", 1'b1, 5'd7, 64'h1234_501C);
    put_inst(64'h20, jal_word(21'd12, 5'd8), "jal_link", 1'b1, 5'd8, 64'h24);
    put_inst(64'h2C, itype_word(12'h041, 5'd0, f3_addi, 5'd10, opc_imm),
             "jal_target", 1'b1, 5'd10, 64'h41);
    // sum 0x41 lands on 0x40
    put_inst(64'h30, itype_word(12'd0, 5'd10, 3'b000, 5'd11, opc_jalr),
             "jalr_odd_sum", 1'b1, 5'd11, 64'h34);
    // x1 = 5 and x2 = -3, signed and unsigned order disagree
    put_inst(64'h40, branch_word(13'd8, 5'd1, 5'd1, f3_beq), "beq_taken", 1'b0, '0, '0);
    put_inst(64'h48, branch_word(13'd8, 5'd1, 5'd2, f3_beq), "beq_not_taken", 1'b0, '0, '0);
    put_inst(64'h4C, branch_word(13'd8, 5'd1, 5'd2, f3_bne), "bne_taken", 1'b0, '0, '0);
    put_inst(64'h54, branch_word(13'd8, 5'd1, 5'd1, f3_bne), "bne_not_taken", 1'b0, '0, '0);
    put_inst(64'h58, branch_word(13'd8, 5'd2, 5'd1, f3_blt), "blt_taken", 1'b0, '0, '0);
    put_inst(64'h60, branch_word(13'd8, 5'd1, 5'd2, f3_blt), "blt_not_taken", 1'b0, '0, '0);
    put_inst(64'h64, branch_word(13'd8, 5'd1, 5'd2, f3_bge), "bge_taken", 1'b0, '0, '0);
    put_inst(64'h6C, branch_word(13'd8, 5'd2, 5'd1, f3_bge), "bge_not_taken", 1'b0, '0, '0);
    put_inst(64'h70, branch_word(13'd8, 5'd1, 5'd2, f3_bltu), "bltu_taken", 1'b0, '0, '0);
    put_inst(64'h78, branch_word(13'd8, 5'd2, 5'd1, f3_bltu), "bltu_not_taken", 1'b0, '0, '0);
    put_inst(64'h7C, branch_word(13'd8, 5'd2, 5'd1, f3_bgeu), "bgeu_taken", 1'b0, '0, '0);
    put_inst(64'h84, branch_word(13'd8, 5'd1, 5'd2, f3_bgeu), "bgeu_not_taken", 1'b0, '0, '0);
    // add x12, x1, x1 is outside the supported set
    put_inst(64'h88, itype_word(12'd1, 5'd1, 3'b000, 5'd12, opc_reg),
             "unsupported_op", 1'b0, '0, '0);
    put_inst(64'h8C, itype_word(12'd1, 5'd12, f3_addi, 5'd13, opc_imm),
             "no_write_from_unsupported", 1'b1, 5'd13, 64'd1);
  endtask

  task automatic check_field(input string name, input string field,
                             input reg_t expected, input reg_t actual);
    checks_run++;
    assert (actual === expected)
      else begin
        $display("FAIL %s %s expected %h actual %h", name, field, expected, actual);
        value_errors++;
      end
  endtask

  // 10 ns before the next rising edge
  task automatic sample_point();
    @(negedge clk);
    #10;
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    n_loaded       = 0;
    value_errors   = 0;
    timeout_errors = 0;
    checks_run     = 0;
    load_program();
    @(posedge clk);
    sample_point();
    // pc parked on the reset vector, fetch and write-back idle
    check_field("reset_hold", "inst_addr", `RESET_PC, inst_addr);
    check_field("reset_hold", "inst_ena", reg_t'(1'b0), reg_t'(inst_ena));
    check_field("reset_hold", "wb_en", reg_t'(1'b0), reg_t'(wb_en));
    @(posedge clk);
    rst <= 1'b0;
    wait_cycles = 0;
    sample_point();
    while (!inst_ena && (wait_cycles < reset_wait)) begin
      sample_point();
      wait_cycles++;
    end
    if (!inst_ena) begin
      $display("inst_ena never rose after reset was released");
      timeout_errors++;
    end else begin
      for (int i = 0; i < n_loaded; i++) begin
        if (i > 0) begin
          sample_point();
        end
        check_field(exp_name[i], "inst_ena", reg_t'(1'b1), reg_t'(inst_ena));
        check_field(exp_name[i], "inst_addr", exp_addr[i], inst_addr);
        check_field(exp_name[i], "wb_en", reg_t'(exp_wen[i]), reg_t'(wb_en));
        if (exp_wen[i]) begin
          check_field(exp_name[i], "wb_addr", reg_t'(exp_waddr[i]), reg_t'(wb_addr));
          check_field(exp_name[i], "wb_data", exp_wdata[i], wb_data);
        end
      end
    end
    $display("checks %0d, value errors %0d, timeouts %0d", checks_run, value_errors,
             timeout_errors);
    if ((value_errors == 0) && (timeout_errors == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
design/rv_pkg.sv
design/if_stage.sv
design/id_stage.sv
design/exe_stage.sv
design/regfile.sv
design/rv_core.sv
verif/rv_core_tb.sv
